//--- bench/crc_stim.txt
# op addr size data expected; op W is a write, R is a read, all other fields hex
# size is HSIZE (0 byte, 1 halfword, 2 word); writes ignore expected, reads ignore data
# Reset values: CR, POL, INIT, IDR, DR
R 00000008 2 00000000 00000000
R 00000014 2 00000000 04C11DB7
R 00000010 2 00000000 FFFFFFFF
R 00000004 2 00000000 00000000
R 00000000 2 00000000 FFFFFFFF
# CRC-32 of word, byte, halfword written back to back
W 00000000 2 FFFFFFFF 00000000
W 00000000 0 00000001 00000000
W 00000000 1 000004C0 00000000
R 00000000 2 00000000 19761DB7
# IDR keeps 8 bits, INIT keeps the word
W 00000004 2 A5A5A5C3 00000000
R 00000004 2 00000000 000000C3
W 00000010 2 12345678 00000000
R 00000010 2 00000000 12345678
# CR reset loads INIT, the INIT write right after waits for the load
W 00000008 2 00000001 00000000
W 00000010 2 00000000 00000000
W 00000000 2 1234567A 00000000
R 00000000 2 00000000 09823B6E
R 00000010 2 00000000 00000000
R 00000008 2 00000000 00000000
# 16-bit, reverse per byte
W 00000014 2 00001021 00000000
W 00000008 2 00000029 00000000
W 00000000 1 00008088 00000000
R 00000000 2 00000000 00003121
# 16-bit, reverse per halfword, reversed output
W 00000008 2 000000C9 00000000
W 00000000 1 00008880 00000000
R 00000000 2 00000000 0000848C
R 00000008 2 00000000 000000C8
# 16-bit, reverse per word
W 00000008 2 00000069 00000000
W 00000000 2 2C480000 00000000
R 00000000 2 00000000 000013C6
# 8-bit, no reversal
W 00000014 2 00000007 00000000
W 00000008 2 00000011 00000000
W 00000000 1 00000102 00000000
R 00000000 2 00000000 0000001B
# 8-bit, reverse per byte, reversed output
W 00000008 2 000000B1 00000000
W 00000000 2 80C00000 00000000
R 00000000 2 00000000 000000D5
# 7-bit, no reversal
W 00000014 2 00000009 00000000
W 00000008 2 00000019 00000000
W 00000000 1 00000105 00000000
R 00000000 2 00000000 00000026
# 7-bit, reverse per halfword, reversed output
W 00000008 2 000000D9 00000000
W 00000000 1 0000A080 00000000
R 00000000 2 00000000 00000032

//--- sources.f
common/crc_pkg.sv
host_interface/crc_host_interface.sv
src/crc_input_buffer.sv
crc_engine/crc_engine.sv
src/crc_output_stage.sv
src/crc_top.sv
bench/crc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run from the project root; exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module crc_tb -f sources.f -o crc_sim &&
./obj_dir/crc_sim &&
echo "simulation run ok" ||
{
	echo "simulation run failed"
	exit 1
}

//--- bench/crc_tb.sv
// Testbench for the CRC unit that replays bench/crc_stim.txt as AHB-Lite transfers
`timescale 1ns/1ps

module crc_tb;

	// One bus transfer as it moves from address phase to data phase
	typedef struct packed {
		logic        valid;
		logic        write;
		logic [2:0]  size;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expected;
	} xfer_t;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Transfer whose data phase is on the bus
	xfer_t  pend;
	integer seed;
	int     fd;
	int     op_count;

	crc_top dut0 (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HWRITE    (HWRITE),
		.HSIZE     (HSIZE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	// 4 ns clock
	always #2 HCLK = ~HCLK;

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("ERR %0t: %s is %08h, expected %08h",
				$time, what, got, expected);
			stop_with_failure("Value mismatch");
		end
	endtask

	// Only DR accesses and INIT writes may be stretched
	// DR sits at word offset 0, INIT at word offset 4
	function automatic logic may_stall(input xfer_t x);
		return x.valid && ((x.addr[4:2] == 3'h0) ||
			(x.write && (x.addr[4:2] == 3'h4)));
	endfunction

	//////////////////////////////////////////////////
	// AHB-Lite driver
	//////////////////////////////////////////////////

	// Sampled at the falling edge where the DUT outputs have settled
	task automatic wait_ready(output int cycles);
		cycles = 0;
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			cycles++;
			if (cycles >= 64)
				stop_with_failure($sformatf("Timeout: HREADYOUT low for 64 cycles at %08h",
					pend.addr));
			@(negedge HCLK);
		end
	endtask

	// Data phase on the bus ends here with HREADYOUT high
	task automatic finish_data_phase(input int waits);
		check_value("HRESP", {31'b0, HRESP}, 32'h0);
		// Idle cycles and the other registers answer without wait states
		if (!may_stall(pend))
			check_value($sformatf("Wait states at %08h", pend.addr), waits, 32'h0);
		if (pend.valid && !pend.write)
			check_value($sformatf("HRDATA at %08h", pend.addr), HRDATA, pend.expected);
	endtask

	// One pipelined bus cycle with the next address phase over the pending data phase
	task automatic bus_step(input xfer_t next);
		int waits;
		@(posedge HCLK);
		// Write data follows its address by one cycle
		if (pend.valid && pend.write)
			HWDATA <= pend.data;
		if (next.valid)
		begin
			HSElx  <= 1'b1;
			HTRANS <= 2'b10;
			HADDR  <= next.addr;
			HWRITE <= next.write;
			HSIZE  <= next.size;
		end
		else
		begin
			HSElx  <= 1'b0;
			HTRANS <= 2'b00;
			HWRITE <= 1'b0;
		end
		wait_ready(waits);
		finish_data_phase(waits);
		pend = next;
	endtask

	//////////////////////////////////////////////////
	// Stimulus file
	//////////////////////////////////////////////////

	// Columns are op, address, size, data and expected read value
	task automatic run_operation(input string line);
		logic [7:0]  op_ch;
		logic [31:0] addr;
		logic [31:0] size;
		logic [31:0] data;
		logic [31:0] expected;
		xfer_t       next;
		int          code;
		int          gap;
		code = $sscanf(line, "%c %h %h %h %h", op_ch, addr, size, data, expected);
		if (code != 5 || (op_ch != "W" && op_ch != "R"))
			stop_with_failure($sformatf("Malformed stimulus line: %s", line));
		next.valid    = 1'b1;
		next.write    = (op_ch == "W");
		next.size     = size[2:0];
		next.addr     = addr;
		next.data     = data;
		next.expected = expected;
		// Writes stay back to back while reads get 0 to 3 idle cycles
		if (!next.write)
		begin
			gap = $random(seed) & 3;
			repeat (gap)
				bus_step('0);
		end
		bus_step(next);
		op_count++;
	endtask

	initial
	begin
		string line;
		int    code;
		HCLK     = 1'b0;
		HRESETn  = 1'b0;
		HSElx    = 1'b0;
		HADDR    = '0;
		HTRANS   = 2'b00;
		HWRITE   = 1'b0;
		HSIZE    = 3'd0;
		HWDATA   = '0;
		// No other slave on the bus can hold HREADY low
		HREADY   = 1'b1;
		pend     = '0;
		seed     = 32'h5eac;
		op_count = 0;

		fd = $fopen("bench/crc_stim.txt", "r");
		if (fd == 0)
			stop_with_failure("Could not open bench/crc_stim.txt");

		// Reset held for 3 cycles
		repeat (3)
			@(posedge HCLK);
		HRESETn <= 1'b1;

		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			// Skip comments and blank lines
			if (code > 0 && line.len() > 1 && line[0] != "#")
				run_operation(line);
		end
		$fclose(fd);

		// Idle cycle drains the last data phase
		bus_step('0);

		if (op_count == 0)
			stop_with_failure("Stimulus file held no operations");
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

//--- src/crc_top.sv
// Top level of the AHB-Lite CRC unit, connects host interface, buffer, engine and output
`timescale 1ns/1ps

module crc_top
	import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  crc_word_t   HWDATA,
	input  logic        HREADY,
	output crc_word_t   HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	crc_word_t  bus_wr;
	bus_size_t  bus_size;
	crc_cfg_t   crc_cfg;
	logic       buffer_write_en;
	logic       crc_init_en;
	logic       crc_idr_en;
	logic       crc_poly_en;
	logic       reset_chain;
	logic       buffer_full;
	logic       buf_valid;
	buf_entry_t buf_entry;
	logic       buf_take;
	crc_word_t  crc_raw;
	logic       crc_busy;
	crc_word_t  crc_poly_out;
	crc_word_t  crc_init_out;
	crc_idr_t   crc_idr_out;
	logic       reset_pending;
	crc_word_t  crc_out;
	logic       result_valid;
	logic       read_wait;

	// DR reads wait for pending data, a busy engine or a stale result
	assign read_wait = buf_valid || crc_busy || !result_valid;

	crc_host_interface host0 (
		.HCLK, .HRESETn, .HSElx, .HADDR, .HTRANS, .HWRITE, .HSIZE, .HWDATA, .HREADY,
		.HRDATA, .HREADYOUT, .HRESP,
		.crc_out, .crc_poly_out, .crc_init_out, .crc_idr_out,
		.buffer_full, .reset_pending, .read_wait,
		.bus_wr, .bus_size, .crc_cfg, .buffer_write_en,
		.crc_init_en, .crc_idr_en, .crc_poly_en, .reset_chain
	);

	crc_input_buffer buf0 (
		.HCLK, .HRESETn, .buffer_write_en, .bus_wr, .bus_size,
		.buffer_full, .buf_valid, .buf_entry, .buf_take
	);

	crc_engine eng0 (
		.HCLK, .HRESETn, .buf_valid, .buf_entry, .crc_cfg, .bus_wr,
		.crc_init_en, .crc_idr_en, .crc_poly_en, .reset_chain,
		.buf_take, .crc_raw, .crc_busy, .crc_poly_out, .crc_init_out,
		.crc_idr_out, .reset_pending
	);

	crc_output_stage out0 (
		.HCLK, .HRESETn, .crc_raw, .crc_busy, .crc_cfg, .crc_out, .result_valid
	);

endmodule

//--- src/crc_output_stage.sv
// Registered output reversal and width mask of the raw CRC value
`timescale 1ns/1ps

module crc_output_stage
	import crc_pkg::*;
(
	input  logic      HCLK,
	input  logic      HRESETn,
	input  crc_word_t crc_raw,
	input  logic      crc_busy,
	input  crc_cfg_t  crc_cfg,
	output crc_word_t crc_out,
	output logic      result_valid
);

	crc_word_t raw_rev;
	crc_word_t out_next;
	crc_word_t out_q;
	crc_cfg_t  cfg_q;
	logic      valid_q;

	//////////////////////////////////////////////////
	// Reversal over the active width
	//////////////////////////////////////////////////

	// Full word mirror first
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			raw_rev[i] = crc_raw[31 - i];
	end

	// Shift the mirrored value down to the active width, then mask
	always_comb
	begin
		if (crc_cfg.rev_out_type)
			out_next = (raw_rev >> (5'd31 - crc_top_bit(crc_cfg.poly_size)))
				& crc_width_mask(crc_cfg.poly_size);
		else
			out_next = crc_raw & crc_width_mask(crc_cfg.poly_size);
	end

	// Result and the config it was formed with
	always_ff @(posedge HCLK)
	begin
		out_q <= out_next;
		cfg_q <= crc_cfg;
	end

	// Valid once the engine has been idle for a cycle
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			valid_q <= 1'b0;
		else
			valid_q <= !crc_busy;
	end

	assign crc_out = out_q;
	// A CR write makes the held result stale for one cycle
	assign result_valid = valid_q && (cfg_q == crc_cfg);

endmodule

//--- crc_engine/crc_engine.sv
// Byte-serial CRC engine with polynomial, init and IDR registers and reset chaining
`timescale 1ns/1ps

module crc_engine
	import crc_pkg::*;
(
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       buf_valid,
	input  buf_entry_t buf_entry,
	input  crc_cfg_t   crc_cfg,
	input  crc_word_t  bus_wr,
	input  logic       crc_init_en,
	input  logic       crc_idr_en,
	input  logic       crc_poly_en,
	input  logic       reset_chain,
	output logic       buf_take,
	output crc_word_t  crc_raw,
	output logic       crc_busy,
	output crc_word_t  crc_poly_out,
	output crc_word_t  crc_init_out,
	output crc_idr_t   crc_idr_out,
	output logic       reset_pending
);

	eng_state_e state_q;
	logic       pend_q;
	logic [1:0] count_q;
	crc_word_t  crc_q;
	crc_word_t  poly_q;
	crc_word_t  init_q;
	crc_idr_t   idr_q;
	crc_word_t  data_q;
	rev_in_t    rev_eff;
	crc_word_t  data_rev;

	//////////////////////////////////////////////////
	// Bit helpers
	//////////////////////////////////////////////////

	// Mirror bits inside each byte, halfword or word
	function automatic crc_word_t reverse_in(crc_word_t d, rev_in_t r);
		crc_word_t o;
		o = d;
		for (int i = 0; i < 32; i++)
		begin
			case (r)
				2'd1: o[i] = d[(i & ~7) + 7 - (i & 7)];
				2'd2: o[i] = d[(i & ~15) + 15 - (i & 15)];
				2'd3: o[i] = d[31 - i];
				default: o[i] = d[i];
			endcase
		end
		return o;
	endfunction

	// Fold one byte into the CRC, MSB first, over the active width
	function automatic crc_word_t fold_byte(crc_word_t crc, logic [7:0] b,
		crc_word_t poly, poly_size_t size);
		crc_word_t  c;
		crc_word_t  m;
		logic [4:0] top;
		logic       fb;
		m   = crc_width_mask(size);
		top = crc_top_bit(size);
		c   = crc & m;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[top] ^ b[i];
			c  = (c << 1) & m;
			if (fb)
				c = c ^ (poly & m);
		end
		return c;
	endfunction

	// Reversal unit never wider than the write itself
	always_comb
	begin
		case (buf_entry.size)
			2'd0: rev_eff = (crc_cfg.rev_in_type != 2'd0) ? 2'd1 : 2'd0;
			2'd1: rev_eff = (crc_cfg.rev_in_type > 2'd2) ? 2'd2 : crc_cfg.rev_in_type;
			default: rev_eff = crc_cfg.rev_in_type;
		endcase
	end

	assign data_rev = reverse_in(buf_entry.data, rev_eff);

	// Older reset requests go first, otherwise start the buffered entry
	assign buf_take = (state_q == ENG_IDLE) && !pend_q && buf_valid;

	//////////////////////////////////////////////////
	// FSM and CRC register
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q <= ENG_IDLE;
			pend_q  <= 1'b0;
			count_q <= 2'd0;
			crc_q   <= CRC_INIT_RESET;
		end
		else
		begin
			case (state_q)
				ENG_IDLE:
				begin
					if (pend_q)
					begin
						state_q <= ENG_LOAD;
						pend_q  <= 1'b0;
					end
					else if (buf_valid)
					begin
						// Byte 1 cycle, halfword 2, word 4
						state_q <= ENG_SHIFT;
						pend_q  <= reset_chain;
						case (buf_entry.size)
							2'd0: count_q <= 2'd0;
							2'd1: count_q <= 2'd1;
							default: count_q <= 2'd3;
						endcase
					end
					else if (reset_chain)
						state_q <= ENG_LOAD;
				end
				ENG_SHIFT:
				begin
					crc_q <= fold_byte(crc_q, data_q[31:24], poly_q, crc_cfg.poly_size);
					if (count_q == 2'd0)
						state_q <= ENG_IDLE;
					else
						count_q <= count_q - 2'd1;
					if (reset_chain)
						pend_q <= 1'b1;
				end
				ENG_LOAD:
				begin
					crc_q   <= init_q;
					state_q <= ENG_IDLE;
					if (reset_chain)
						pend_q <= 1'b1;
				end
				default: state_q <= ENG_IDLE;
			endcase
		end
	end

	// Data shifter, left aligned so the next byte sits at the top
	always_ff @(posedge HCLK)
	begin
		if (buf_take)
		begin
			case (buf_entry.size)
				2'd0: data_q <= {data_rev[7:0], 24'h0};
				2'd1: data_q <= {data_rev[15:0], 16'h0};
				default: data_q <= data_rev;
			endcase
		end
		else if (state_q == ENG_SHIFT)
			data_q <= data_q << 8;
	end

	//////////////////////////////////////////////////
	// Programmable registers
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			poly_q <= CRC_POLY_RESET;
			init_q <= CRC_INIT_RESET;
			idr_q  <= '0;
		end
		else
		begin
			if (crc_poly_en)
				poly_q <= bus_wr;
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
		end
	end

	assign crc_raw       = crc_q;
	assign crc_busy      = (state_q != ENG_IDLE) || pend_q;
	assign reset_pending = pend_q || (state_q == ENG_LOAD);
	assign crc_poly_out  = poly_q;
	assign crc_init_out  = init_q;
	assign crc_idr_out   = idr_q;

	// Taking an entry always starts a shift sequence
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buf_take |-> (state_q == ENG_IDLE) ##1 (state_q == ENG_SHIFT));

endmodule

//--- src/crc_input_buffer.sv
// One-entry buffer holding a CRC_DR write and its size until the engine takes it
`timescale 1ns/1ps

module crc_input_buffer
	import crc_pkg::*;
(
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       buffer_write_en,
	input  crc_word_t  bus_wr,
	input  bus_size_t  bus_size,
	output logic       buffer_full,
	output logic       buf_valid,
	output buf_entry_t buf_entry,
	input  logic       buf_take
);

	logic       valid_q;
	buf_entry_t entry_q;

	//////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////

	// A write refills the slot and a take alone empties it
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			valid_q <= 1'b0;
		else if (buffer_write_en)
			valid_q <= 1'b1;
		else if (buf_take)
			valid_q <= 1'b0;
	end

	// Payload
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
		begin
			entry_q.data <= bus_wr;
			entry_q.size <= bus_size;
		end
	end

	// The slot frees up in the cycle the engine takes it
	assign buffer_full = valid_q && !buf_take;
	assign buf_valid   = valid_q;
	assign buf_entry   = entry_q;

	// Host must never write over a held entry
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

endmodule

//--- host_interface/crc_host_interface.sv
// AHB-Lite slave of the CRC unit: register decode, CRC_CR, read mux and wait states
`timescale 1ns/1ps

module crc_host_interface
	import crc_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  crc_word_t   HWDATA,
	input  logic        HREADY,
	output crc_word_t   HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	input  crc_word_t   crc_out,
	input  crc_word_t   crc_poly_out,
	input  crc_word_t   crc_init_out,
	input  crc_idr_t    crc_idr_out,
	input  logic        buffer_full,
	input  logic        reset_pending,
	input  logic        read_wait,
	output crc_word_t   bus_wr,
	output bus_size_t   bus_size,
	output crc_cfg_t    crc_cfg,
	output logic        buffer_write_en,
	output logic        crc_init_en,
	output logic        crc_idr_en,
	output logic        crc_poly_en,
	output logic        reset_chain
);

	//////////////////////////////////////////////////
	// Address phase pipeline
	//////////////////////////////////////////////////

	logic       hselx_pp;
	logic [1:0] htrans_pp;
	logic [2:0] haddr_pp;
	bus_size_t  hsize_pp;
	logic       hwrite_pp;

	logic      sample_bus;
	logic      write_en;
	logic      read_en;
	logic      dr_write;
	logic      dr_read;
	logic      init_write;
	logic      cr_write;
	crc_cfg_t  crc_cfg_q;

	// Control part of the address phase
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= 2'b00;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
		end
	end

	// Address, size and direction only matter while hselx_pp is set
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	// BUSY and SEQ behave as IDLE
	assign write_en = hselx_pp && (htrans_pp == HTRANS_NONSEQ) && hwrite_pp;
	assign read_en  = hselx_pp && (htrans_pp == HTRANS_NONSEQ) && !hwrite_pp;

	assign dr_write   = write_en && (haddr_pp == CRC_DR);
	assign dr_read    = read_en && (haddr_pp == CRC_DR);
	assign init_write = write_en && (haddr_pp == CRC_INIT);
	assign cr_write   = write_en && (haddr_pp == CRC_CR);

	// Stalled writes fire only in the cycle they complete
	assign buffer_write_en = dr_write && !buffer_full;
	assign crc_init_en     = init_write && !reset_pending;
	assign crc_idr_en      = write_en && (haddr_pp == CRC_IDR);
	assign crc_poly_en     = write_en && (haddr_pp == CRC_POL);

	// Self-clearing reset bit, never stored
	assign reset_chain = cr_write && HWDATA[0];

	// Write data is taken straight from the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Wait states from the three stall conditions
	assign HREADYOUT = !((dr_write && buffer_full) ||
		(dr_read && read_wait) ||
		(init_write && reset_pending));

	assign sample_bus = HREADY && HREADYOUT;

	// No error responses
	assign HRESP = 1'b0;

	//////////////////////////////////////////////////
	// CRC_CR
	//////////////////////////////////////////////////
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cfg_q <= '0;
		else if (cr_write)
			crc_cfg_q <= crc_cfg_t'(HWDATA[7:3]);
	end

	assign crc_cfg = crc_cfg_q;

	// Read mux, data phase address
	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			CRC_CR:   HRDATA = {24'h0, crc_cfg_q, 3'h0};
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = '0;
		endcase
	end

	// At most one register strobe per cycle
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$onehot0({buffer_write_en, crc_init_en, crc_idr_en, crc_poly_en, reset_chain}));

	// A DR read that must wait keeps the transfer pending
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_read && read_wait) |-> !HREADYOUT ##1 dr_read);

endmodule

//--- common/crc_pkg.sv
// Shared CRC unit types, register offsets and width helpers, imported by every RTL block
package crc_pkg;

	//////////////////////////////////////////////////
	// Widths that carry a meaning
	//////////////////////////////////////////////////

	// Data and CRC words
	typedef logic [31:0] crc_word_t;
	// Independent data register
	typedef logic [7:0] crc_idr_t;
	// Polynomial size code: 0 is 32, 1 is 16, 2 is 8, 3 is 7 bits
	typedef logic [1:0] poly_size_t;
	// Write size from HSIZE: 0 byte, 1 halfword, 2 word
	typedef logic [1:0] bus_size_t;
	// Input reversal: 0 none, 1 byte, 2 halfword, 3 word
	typedef logic [1:0] rev_in_t;

	// CRC_CR fields, packed to match CR bits 7:3
	typedef struct packed {
		logic       rev_out_type;
		rev_in_t    rev_in_type;
		poly_size_t poly_size;
	} crc_cfg_t;

	// One buffered data write
	typedef struct packed {
		crc_word_t data;
		bus_size_t size;
	} buf_entry_t;

	// Engine FSM
	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_SHIFT,
		ENG_LOAD
	} eng_state_e;

	//////////////////////////////////////////////////
	// Register map, word address bits 4:2
	//////////////////////////////////////////////////
	localparam logic [2:0] CRC_DR   = 3'h0;
	localparam logic [2:0] CRC_IDR  = 3'h1;
	localparam logic [2:0] CRC_CR   = 3'h2;
	localparam logic [2:0] CRC_INIT = 3'h4;
	localparam logic [2:0] CRC_POL  = 3'h5;

	// AHB transfer type that starts a transfer
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	// Reset values
	localparam crc_word_t CRC_POLY_RESET = 32'h04C11DB7;
	localparam crc_word_t CRC_INIT_RESET = 32'hFFFFFFFF;

	// Index of the CRC top bit for a polynomial size
	function automatic logic [4:0] crc_top_bit(poly_size_t size);
		case (size)
			2'd1: return 5'd15;
			2'd2: return 5'd7;
			2'd3: return 5'd6;
			default: return 5'd31;
		endcase
	endfunction

	// Ones over the active CRC width
	function automatic crc_word_t crc_width_mask(poly_size_t size);
		case (size)
			2'd1: return 32'h0000FFFF;
			2'd2: return 32'h000000FF;
			2'd3: return 32'h0000007F;
			default: return 32'hFFFFFFFF;
		endcase
	endfunction

endpackage
